// ==== design/audio_mixer.sv ====
/*
 * Stereo audio path. Stage 1 cross-feeds the channels by the mix setting,
 * stage 2 applies the host volume as a right shift or mutes.
 */
`timescale 1ns/1ns
`default_nettype none

module audio_mixer (
	input  wire                   clk_sys,
	input  wire                   resetd,
	input  wire sys_pkg::sample_t i_audio_l,
	input  wire sys_pkg::sample_t i_audio_r,
	input  wire                   i_audio_s,
	input  wire [1:0]             i_audio_mix,
	input  wire                   i_vol_we,
	input  wire sys_pkg::io_word_t i_wdata,
	output sys_pkg::sample_t      o_audio_l,
	output sys_pkg::sample_t      o_audio_r
);

	sys_pkg::vol_t    vol_q;
	sys_pkg::sample_t mix_l;
	sys_pkg::sample_t mix_r;
	logic             mix_s;

	// Own channel blended with the other one, shifts follow the sample sign
	function automatic sys_pkg::sample_t xfeed(
		input sys_pkg::sample_t own,
		input sys_pkg::sample_t other,
		input logic [1:0]       mix,
		input logic             arith
	);
		sys_pkg::sample_t own_8;
		sys_pkg::sample_t own_4;
		sys_pkg::sample_t own_2;
		sys_pkg::sample_t oth_8;
		sys_pkg::sample_t oth_4;
		sys_pkg::sample_t oth_2;
		own_8 = arith ? (own >>> 3) : (own >> 3);
		own_4 = arith ? (own >>> 2) : (own >> 2);
		own_2 = arith ? (own >>> 1) : (own >> 1);
		oth_8 = arith ? (other >>> 3) : (other >> 3);
		oth_4 = arith ? (other >>> 2) : (other >> 2);
		oth_2 = arith ? (other >>> 1) : (other >> 1);
		case (mix)
			2'd0:    return own;
			2'd1:    return own - own_8 + oth_8;
			2'd2:    return own - own_4 + oth_4;
			default: return own_2 + oth_2;
		endcase
	endfunction

	// Volume register
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			vol_q <= '0;
		end else if (i_vol_we) begin
			vol_q <= i_wdata[sys_pkg::VOL_W-1:0];
		end
	end

	// Stage 1, signed flag travels along with the samples
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
			mix_s <= 1'b0;
		end else begin
			mix_l <= xfeed(i_audio_l, i_audio_r, i_audio_mix, i_audio_s);
			mix_r <= xfeed(i_audio_r, i_audio_l, i_audio_mix, i_audio_s);
			mix_s <= i_audio_s;
		end
	end

	// Stage 2
	always_ff @(posedge clk_sys) begin
		if (resetd || vol_q[sys_pkg::VOL_W-1]) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else if (mix_s) begin
			o_audio_l <= mix_l >>> vol_q[3:0];
			o_audio_r <= mix_r >>> vol_q[3:0];
		end else begin
			o_audio_l <= mix_l >> vol_q[3:0];
			o_audio_r <= mix_r >> vol_q[3:0];
		end
	end

endmodule

`default_nettype wire

// ==== design/board_leds.sv ====
/*
 * Main-board LEDs. Core status bits shown by default, host override mask
 * and state replace them bit by bit.
 */
`timescale 1ns/1ns
`default_nettype none

module board_leds (
	input  wire                    clk_sys,
	input  wire                    resetd,
	input  wire                    i_led_we,
	input  wire sys_pkg::io_word_t i_wdata,
	input  wire                    i_led_user,
	input  wire [1:0]              i_led_power,
	input  wire [1:0]              i_led_disk,
	input  wire                    i_locked,
	output sys_pkg::led_t          o_led
);

	sys_pkg::led_t led_mask;
	sys_pkg::led_t led_state;
	sys_pkg::led_t status;
	logic          power_lit;
	logic          disk_lit;

	// Upper byte is the mask, lower byte the forced state
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led_mask  <= '0;
			led_state <= '0;
		end else if (i_led_we) begin
			led_mask  <= i_wdata[15:8];
			led_state <= i_wdata[7:0];
		end
	end

	assign power_lit = i_led_power[1] & ~i_led_power[0];
	assign disk_lit  = i_led_disk[0];

	assign status = {1'b0, i_locked, 1'b0, power_lit, 1'b0, disk_lit, 1'b0, i_led_user};

	assign o_led = (led_mask & led_state) | (~led_mask & status);

endmodule

`default_nettype wire

// ==== design/sync_polarity.sv ====
/*
 * Sync polarity normaliser. Compares the high and low phase lengths of
 * one sync input and inverts it when needed so pulses are active high.
 */
`timescale 1ns/1ns
`default_nettype none

module sync_polarity #(
	parameter int CNT_W = sys_pkg::SYNC_CNT_W
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);

	logic             sync_d1;
	logic             sync_d2;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             flip;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_d1  <= 1'b0;
			sync_d2  <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			flip     <= 1'b0;
		end else begin
			sync_d1 <= i_sync;
			sync_d2 <= sync_d1;
			// Rising edge ends a low phase, falling edge a high phase
			if (!sync_d2 && sync_d1) low_len <= cnt;
			if (sync_d2 && !sync_d1) high_len <= cnt;
			cnt  <= (sync_d2 != sync_d1) ? '0 : cnt + 1'b1;
			flip <= (high_len > low_len);
		end
	end

	assign o_sync = i_sync ^ flip;

endmodule

`default_nettype wire

// ==== design/sys_core.sv ====
/*
 * Top level. Host command decoder feeding the audio mixer, the VGA sync
 * output stage and the board LED stage, all on clk_sys.
 */
`timescale 1ns/1ns
`default_nettype none

module sys_core #(
	parameter int SYNC_CNT_W_P = sys_pkg::SYNC_CNT_W
) (
	input  wire                    clk_sys,
	input  wire                    resetd,
	// Host channel
	input  wire                    i_io_uio,
	input  wire                    i_io_clk,
	input  wire sys_pkg::io_word_t i_io_din,
	output logic                   o_io_ack,
	// Audio
	input  wire sys_pkg::sample_t  i_audio_l,
	input  wire sys_pkg::sample_t  i_audio_r,
	input  wire                    i_audio_s,
	input  wire [1:0]              i_audio_mix,
	output sys_pkg::sample_t       o_audio_l,
	output sys_pkg::sample_t       o_audio_r,
	// Video
	input  wire                    i_hs,
	input  wire                    i_vs,
	output logic                   o_vga_hs,
	output logic                   o_vga_vs,
	// LEDs
	input  wire                    i_led_user,
	input  wire [1:0]              i_led_power,
	input  wire [1:0]              i_led_disk,
	input  wire                    i_locked,
	output sys_pkg::led_t          o_led
);

	sys_pkg::io_word_t wdata;
	logic              cfg_we;
	logic              led_we;
	logic              vol_we;

	// ========================================================================
	// Decode
	// ========================================================================

	uio_cmd_decode u_cmd_decode (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_uio (i_io_uio),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.o_wdata  (wdata),
		.o_cfg_we (cfg_we),
		.o_led_we (led_we),
		.o_vol_we (vol_we)
	);

	// ========================================================================
	// Targets
	// ========================================================================

	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_audio_l   (i_audio_l),
		.i_audio_r   (i_audio_r),
		.i_audio_s   (i_audio_s),
		.i_audio_mix (i_audio_mix),
		.i_vol_we    (vol_we),
		.i_wdata     (wdata),
		.o_audio_l   (o_audio_l),
		.o_audio_r   (o_audio_r)
	);

	vga_sync_out #(.SYNC_CNT_W_P(SYNC_CNT_W_P)) u_vga_sync_out (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_hs     (i_hs),
		.i_vs     (i_vs),
		.i_cfg_we (cfg_we),
		.i_wdata  (wdata),
		.o_vga_hs (o_vga_hs),
		.o_vga_vs (o_vga_vs)
	);

	board_leds u_board_leds (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_led_we    (led_we),
		.i_wdata     (wdata),
		.i_led_user  (i_led_user),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.i_locked    (i_locked),
		.o_led       (o_led)
	);

endmodule

`default_nettype wire

// ==== design/sys_pkg.sv ====
/*
 * Shared definitions for the host command channel and its targets.
 * Referenced by scoped names from the design and the testbench.
 */
`default_nettype none

package sys_pkg;

	// Host word
	localparam int IO_W = 16;
	typedef logic [IO_W-1:0] io_word_t;

	// Command codes, taken from the first word of a frame
	typedef logic [7:0] cmd_t;
	localparam cmd_t CMD_CFG = 8'h01;
	localparam cmd_t CMD_LED = 8'h25;
	localparam cmd_t CMD_VOL = 8'h26;

	// Configuration word fields
	localparam int CFG_CSYNC_BIT = 3;

	// Audio
	localparam int SAMPLE_W = 16;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Attenuation: bit 4 mutes, bits 3:0 are the shift count
	localparam int VOL_W = 5;
	typedef logic [VOL_W-1:0] vol_t;

	// Main-board LEDs
	localparam int LED_W = 8;
	typedef logic [LED_W-1:0] led_t;

	// Sync duration counters
	localparam int SYNC_CNT_W = 16;

endpackage

`default_nettype wire

// ==== design/uio_cmd_decode.sv ====
/*
 * Host command channel. Turns the strobe/ack level toggles into accepted
 * words, frames them into command and data, and pulses one write strobe
 * per data word for the target selected by the command.
 */
`timescale 1ns/1ns
`default_nettype none

module uio_cmd_decode (
	input  wire              clk_sys,
	input  wire              resetd,
	input  wire              i_io_uio,
	input  wire              i_io_clk,
	input  wire sys_pkg::io_word_t i_io_din,
	output logic             o_io_ack,
	output sys_pkg::io_word_t o_wdata,
	output logic             o_cfg_we,
	output logic             o_led_we,
	output logic             o_vol_we
);

	logic          io_clk_q;
	logic          io_strobe;
	logic          has_cmd;
	sys_pkg::cmd_t cmd_q;

	// High for one cycle on the rising strobe level
	assign io_strobe = i_io_clk & ~io_clk_q;

	// ========================================================================
	// Handshake
	// ========================================================================

	// Ack is the strobe level two cycles late
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_q <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			io_clk_q <= i_io_clk;
			o_io_ack <= io_clk_q;
		end
	end

	// ========================================================================
	// Framing
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			o_cfg_we <= 1'b0;
			o_led_we <= 1'b0;
			o_vol_we <= 1'b0;
		end else begin
			o_cfg_we <= 1'b0;
			o_led_we <= 1'b0;
			o_vol_we <= 1'b0;
			if (!i_io_uio) begin
				// Frame closed, next word is a command
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
				end else begin
					// Unknown codes match nothing
					o_cfg_we <= (cmd_q == sys_pkg::CMD_CFG);
					o_led_we <= (cmd_q == sys_pkg::CMD_LED);
					o_vol_we <= (cmd_q == sys_pkg::CMD_VOL);
				end
			end
		end
	end

	// Command byte and data word
	always_ff @(posedge clk_sys) begin
		if (i_io_uio && io_strobe) begin
			if (!has_cmd) begin
				cmd_q <= i_io_din[7:0];
			end else begin
				o_wdata <= i_io_din;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/vga_sync_out.sv ====
/*
 * VGA sync output stage. Holds the host configuration word and drives
 * separate active-low syncs, or composite sync on HS when csync is set.
 */
`timescale 1ns/1ns
`default_nettype none

module vga_sync_out #(
	parameter int SYNC_CNT_W_P = sys_pkg::SYNC_CNT_W
) (
	input  wire                    clk_sys,
	input  wire                    resetd,
	input  wire                    i_hs,
	input  wire                    i_vs,
	input  wire                    i_cfg_we,
	input  wire sys_pkg::io_word_t i_wdata,
	output logic                   o_vga_hs,
	output logic                   o_vga_vs
);

	sys_pkg::io_word_t cfg_q;
	logic              csync;
	logic              hs_pos;
	logic              vs_pos;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg_q <= '0;
		end else if (i_cfg_we) begin
			cfg_q <= i_wdata;
		end
	end

	assign csync = cfg_q[sys_pkg::CFG_CSYNC_BIT];

	sync_polarity #(.CNT_W(SYNC_CNT_W_P)) u_hs_pol (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_pos)
	);

	sync_polarity #(.CNT_W(SYNC_CNT_W_P)) u_vs_pol (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_pos)
	);

	// Composite sync goes out on the HS pin, VS parks high
	assign o_vga_hs = csync ? ~(hs_pos ^ vs_pos) : ~hs_pos;
	assign o_vga_vs = csync ? 1'b1 : ~vs_pos;

endmodule

`default_nettype wire

// ==== dv/sys_core_properties.sv ====
/*
 * Concurrent checks on the top level, bound into sys_core. Covers the
 * handshake ack timing, mute behaviour and the parked VS pin in csync mode.
 */
`timescale 1ns/1ns
`default_nettype none

module sys_core_properties (
	input wire                    clk_sys,
	input wire                    resetd,
	input wire                    i_io_clk,
	input wire                    o_io_ack,
	input wire                    vol_we,
	input wire                    cfg_we,
	input wire sys_pkg::io_word_t wdata,
	input wire sys_pkg::sample_t  o_audio_l,
	input wire sys_pkg::sample_t  o_audio_r,
	input wire                    o_vga_vs
);

	logic csync_q;

	// Local copy of the csync configuration bit
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			csync_q <= 1'b0;
		end else if (cfg_we) begin
			csync_q <= wdata[sys_pkg::CFG_CSYNC_BIT];
		end
	end

	ack_after_strobe: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(o_io_ack) |-> ($past(i_io_clk, 2) && !$past(i_io_clk, 3)))
		else $error("o_io_ack rose without a strobe rise two cycles before");

	// Volume register lands one edge after the pulse, stage 2 one edge later
	mute_gives_zero: assert property (@(posedge clk_sys) disable iff (resetd)
		($past(vol_we, 2) && $past(wdata[sys_pkg::VOL_W-1], 2))
		|-> (o_audio_l == '0 && o_audio_r == '0))
		else $error("audio outputs not zero after a mute write");

	vs_parked_in_csync: assert property (@(posedge clk_sys) disable iff (resetd)
		csync_q |-> o_vga_vs)
		else $error("o_vga_vs low while composite sync is selected");

endmodule

bind sys_core sys_core_properties u_sys_core_properties (
	.clk_sys   (clk_sys),
	.resetd    (resetd),
	.i_io_clk  (i_io_clk),
	.o_io_ack  (o_io_ack),
	.vol_we    (vol_we),
	.cfg_we    (cfg_we),
	.wdata     (wdata),
	.o_audio_l (o_audio_l),
	.o_audio_r (o_audio_r),
	.o_vga_vs  (o_vga_vs)
);

`default_nettype wire

// ==== dv/tb_clock.sv ====
/*
 * Testbench clock and reset source. Free-running clk_sys and an active-high
 * synchronous reset held for a fixed number of cycles.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Release just after an edge, like the other testbench drives
	initial begin
		resetd = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/tb_sys_core.sv ====
/*
 * Testbench for sys_core. Runs a table of host frames and audio/LED inputs
 * against reference models, then drives VGA sync waveforms with and
 * without composite sync. Stops at the first mismatch.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_sys_core;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_STEPS  = 30;
	// {locked, disk[1:0], power[1:0], user}
	localparam logic [5:0] INIT_LEDS = 6'b101101;

	typedef struct packed {
		logic [1:0]        nwords;
		sys_pkg::cmd_t     cmd;
		sys_pkg::io_word_t w0;
		sys_pkg::io_word_t w1;
		sys_pkg::sample_t  l;
		sys_pkg::sample_t  r;
		logic              s;
		logic [1:0]        mix;
		logic [5:0]        led_in;
		sys_pkg::sample_t  exp_l;
		sys_pkg::sample_t  exp_r;
		sys_pkg::led_t     exp_led;
	} step_t;

	logic              clk_sys;
	logic              resetd;
	logic              i_io_uio;
	logic              i_io_clk;
	sys_pkg::io_word_t i_io_din;
	logic              o_io_ack;
	sys_pkg::sample_t  i_audio_l;
	sys_pkg::sample_t  i_audio_r;
	logic              i_audio_s;
	logic [1:0]        i_audio_mix;
	sys_pkg::sample_t  o_audio_l;
	sys_pkg::sample_t  o_audio_r;
	logic              i_hs;
	logic              i_vs;
	logic              o_vga_hs;
	logic              o_vga_vs;
	logic              i_led_user;
	logic [1:0]        i_led_power;
	logic [1:0]        i_led_disk;
	logic              i_locked;
	sys_pkg::led_t     o_led;

	step_t         steps [NUM_STEPS];
	logic [31:0]   seed;
	sys_pkg::vol_t m_vol;
	sys_pkg::led_t m_mask;
	sys_pkg::led_t m_state;
	logic          verdict_printed;

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_tb_clock (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	sys_core u_sys_core (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.i_audio_l   (i_audio_l),
		.i_audio_r   (i_audio_r),
		.i_audio_s   (i_audio_s),
		.i_audio_mix (i_audio_mix),
		.o_audio_l   (o_audio_l),
		.o_audio_r   (o_audio_r),
		.i_hs        (i_hs),
		.i_vs        (i_vs),
		.o_vga_hs    (o_vga_hs),
		.o_vga_vs    (o_vga_vs),
		.i_led_user  (i_led_user),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.i_locked    (i_locked),
		.o_led       (o_led)
	);

	// ========================================================================
	// Reference models
	// ========================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// One bit at a time, refilling the top with the sign when arithmetic
	function automatic logic [15:0] shift_right(input logic [15:0] v, input logic [3:0] n,
		input logic arith);
		logic [15:0] r;
		int          i;
		r = v;
		for (i = 0; i < int'(n); i++) begin
			r = {arith & r[15], r[15:1]};
		end
		return r;
	endfunction

	function automatic logic [15:0] mix_model(input logic [15:0] own, input logic [15:0] other,
		input logic [1:0] mix, input logic arith);
		case (mix)
			2'd0:    return own;
			2'd1:    return own - shift_right(own, 4'd3, arith) + shift_right(other, 4'd3, arith);
			2'd2:    return own - shift_right(own, 4'd2, arith) + shift_right(other, 4'd2, arith);
			default: return shift_right(own, 4'd1, arith) + shift_right(other, 4'd1, arith);
		endcase
	endfunction

	function automatic logic [15:0] atten_model(input logic [15:0] mixed,
		input sys_pkg::vol_t vol, input logic arith);
		if (vol[4]) begin
			return 16'h0000;
		end
		return shift_right(mixed, vol[3:0], arith);
	endfunction

	function automatic sys_pkg::led_t led_model(input logic [5:0] led_in,
		input sys_pkg::led_t mask, input sys_pkg::led_t state);
		sys_pkg::led_t status;
		sys_pkg::led_t led;
		int            b;
		status    = 8'h00;
		status[0] = led_in[0];
		status[2] = led_in[3];
		status[4] = led_in[2] & ~led_in[1];
		status[6] = led_in[5];
		for (b = 0; b < sys_pkg::LED_W; b++) begin
			led[b] = mask[b] ? state[b] : status[b];
		end
		return led;
	endfunction

	// ========================================================================
	// Reporting
	// ========================================================================

	task automatic stop_on_failure();
		verdict_printed = 1'b1;
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	// ========================================================================
	// Host channel and input drivers
	// ========================================================================

	// Called 1 ns after a rising edge, returns at the same point
	task automatic send_word(input sys_pkg::io_word_t w);
		int n;
		i_io_din = w;
		i_io_clk = 1'b1;
		n = 0;
		while (!o_io_ack) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		check_eq("o_io_ack rise delay", 16'd2, 16'(n));
		i_io_clk = 1'b0;
		n = 0;
		while (o_io_ack) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		check_eq("o_io_ack fall delay", 16'd2, 16'(n));
	endtask

	task automatic send_frame(input sys_pkg::cmd_t cmd, input logic [1:0] nwords,
		input sys_pkg::io_word_t w0, input sys_pkg::io_word_t w1);
		i_io_uio = 1'b1;
		send_word({8'h00, cmd});
		send_word(w0);
		if (nwords == 2'd2) begin
			send_word(w1);
		end
		i_io_uio = 1'b0;
		repeat (2) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic apply_leds(input logic [5:0] v);
		i_led_user  = v[0];
		i_led_power = v[2:1];
		i_led_disk  = v[4:3];
		i_locked    = v[5];
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================

	task automatic add_step(input int idx, input logic [1:0] nwords, input sys_pkg::cmd_t cmd,
		input sys_pkg::io_word_t w0, input sys_pkg::io_word_t w1, input logic [1:0] mix,
		input logic s);
		step_t             st;
		sys_pkg::io_word_t last;
		seed = lcg_next(seed);
		st.l = seed[31:16];
		seed = lcg_next(seed);
		st.r = seed[31:16];
		seed = lcg_next(seed);
		st.led_in = seed[21:16];
		st.nwords = nwords;
		st.cmd    = cmd;
		st.w0     = w0;
		st.w1     = w1;
		st.mix    = mix;
		st.s      = s;
		// Last data word of a frame is the one that sticks
		last = (nwords == 2'd2) ? w1 : w0;
		if (nwords != 2'd0 && cmd == sys_pkg::CMD_VOL) begin
			m_vol = last[4:0];
		end
		if (nwords != 2'd0 && cmd == sys_pkg::CMD_LED) begin
			m_mask  = last[15:8];
			m_state = last[7:0];
		end
		st.exp_l   = atten_model(mix_model(st.l, st.r, mix, s), m_vol, s);
		st.exp_r   = atten_model(mix_model(st.r, st.l, mix, s), m_vol, s);
		st.exp_led = led_model(st.led_in, m_mask, m_state);
		steps[idx] = st;
	endtask

	task automatic build_table();
		int i;
		seed    = 32'h253f_7076;
		m_vol   = 5'd0;
		m_mask  = 8'h00;
		m_state = 8'h00;
		// Every mix setting, unsigned then signed
		for (i = 0; i < 8; i++) begin
			add_step(i, 2'd0, 8'h00, 16'h0000, 16'h0000, 2'(i % 4), i >= 4);
		end
		// Shift counts 0 to 15
		for (i = 0; i < 16; i++) begin
			add_step(8 + i, 2'd1, sys_pkg::CMD_VOL, 16'(i), 16'h0000, 2'(i), i[2]);
		end
		add_step(24, 2'd1, sys_pkg::CMD_VOL, 16'h0010, 16'h0000, 2'd1, 1'b1);
		add_step(25, 2'd2, sys_pkg::CMD_VOL, 16'h0010, 16'h0003, 2'd2, 1'b1);
		// Unknown command, data would show on csync, mute or the LEDs if it leaked
		add_step(26, 2'd1, 8'h77, 16'hff1f, 16'h0000, 2'd3, 1'b0);
		add_step(27, 2'd1, sys_pkg::CMD_LED, 16'hf0a5, 16'h0000, 2'd0, 1'b1);
		add_step(28, 2'd0, 8'h00, 16'h0000, 16'h0000, 2'd1, 1'b0);
		add_step(29, 2'd2, sys_pkg::CMD_LED, 16'hffff, 16'h0f3c, 2'd3, 1'b1);
	endtask

	task automatic run_step(input step_t st);
		if (st.nwords != 2'd0) begin
			send_frame(st.cmd, st.nwords, st.w0, st.w1);
		end
		i_audio_l   = st.l;
		i_audio_r   = st.r;
		i_audio_s   = st.s;
		i_audio_mix = st.mix;
		apply_leds(st.led_in);
		repeat (2) begin
			@(posedge clk_sys);
			#1;
		end
		check_eq("o_audio_l", st.exp_l, o_audio_l);
		check_eq("o_audio_r", st.exp_r, o_audio_r);
		check_eq("o_led", {8'h00, st.exp_led}, {8'h00, o_led});
		@(posedge clk_sys);
		#1;
	endtask

	// ========================================================================
	// VGA sync
	// ========================================================================

	// HS period 16 with 2 low, VS period 48 with 4 low, three VS periods
	task automatic check_sync_run(input logic csync_on);
		logic hs;
		logic vs;
		logic exp_hs;
		logic exp_vs;
		int   t;
		for (t = 0; t < 144; t++) begin
			hs   = (t % 16) >= 2;
			vs   = (t % 48) >= 4;
			i_hs = hs;
			i_vs = vs;
			@(posedge clk_sys);
			#1;
			if (t >= 96) begin
				// Short low phases, so separate syncs follow the raw inputs
				// and composite sync is low while exactly one input is low
				if (csync_on) begin
					exp_hs = (hs == vs);
					exp_vs = 1'b1;
				end else begin
					exp_hs = hs;
					exp_vs = vs;
				end
				check_eq("o_vga_hs", {15'h0000, exp_hs}, {15'h0000, o_vga_hs});
				check_eq("o_vga_vs", {15'h0000, exp_vs}, {15'h0000, o_vga_vs});
			end
		end
		i_hs = 1'b1;
		i_vs = 1'b1;
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		int i;
		verdict_printed = 1'b0;
		i_io_uio    = 1'b0;
		i_io_clk    = 1'b0;
		i_io_din    = 16'h0000;
		// Nonzero samples through reset, the outputs must still read zero
		i_audio_l   = 16'sh1357;
		i_audio_r   = 16'sh2468;
		i_audio_s   = 1'b0;
		i_audio_mix = 2'd0;
		i_hs        = 1'b1;
		i_vs        = 1'b1;
		apply_leds(INIT_LEDS);
		build_table();

		@(negedge resetd);
		check_eq("o_io_ack", 16'h0000, {15'h0000, o_io_ack});
		check_eq("o_audio_l", 16'h0000, o_audio_l);
		check_eq("o_audio_r", 16'h0000, o_audio_r);
		check_eq("o_led", {8'h00, led_model(INIT_LEDS, 8'h00, 8'h00)}, {8'h00, o_led});

		for (i = 0; i < NUM_STEPS; i++) begin
			run_step(steps[i]);
		end

		check_sync_run(1'b0);
		send_frame(sys_pkg::CMD_CFG, 2'd1, 16'h0008, 16'h0000);
		check_sync_run(1'b1);

		verdict_printed = 1'b1;
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Watchdog, sized from the table length plus the sync runs
	initial begin
		#((NUM_STEPS * 40 + 2000) * CLK_PERIOD);
		$display("Timeout: the run did not finish in the expected time");
		stop_on_failure();
	end

	// A run stopped by a bound assertion ends here without a verdict
	final begin
		if (!verdict_printed) begin
			$display("SOME TESTS FAILED");
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
design/sys_pkg.sv
design/uio_cmd_decode.sv
design/audio_mixer.sv
design/sync_polarity.sv
design/vga_sync_out.sv
design/board_leds.sv
design/sys_core.sv
dv/tb_clock.sv
dv/sys_core_properties.sv
dv/tb_sys_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; the pass line in the output decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_sys_core -f list.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^ALL TESTS PASSED$" \
	&& { echo "Simulation result: pass"; exit 0; } \
	|| { echo "Simulation result: fail"; exit 1; }
